// File: logic/control_unit.sv
`timescale 1ns/1ps
`include "cu_defs.svh"

module control_unit (
	input logic clk,
	input logic arst_n,
	input logic [`CU_IR_W-1:0] ir,
	input logic z,
	input logic en,
	output cu_pkg::ctrl_word_t ctrl
);
	import cu_pkg::*;

	decoded_instr_t dec;
	stage_e stage;

	instr_decoder decoder_i (
		.ir (ir),
		.dec (dec)
	);

	stage_sequencer sequencer_i (
		.clk (clk),
		.arst_n (arst_n),
		.cls (dec.cls),
		.z (z),
		.en (en),
		.stage (stage)
	);

	control_word_gen word_gen_i (
		.stage (stage),
		.dec (dec),
		.ctrl (ctrl)
	);

endmodule

// File: logic/control_word_gen.sv
`timescale 1ns/1ps
`include "cu_defs.svh"

module control_word_gen (
	input cu_pkg::stage_e stage,
	input cu_pkg::decoded_instr_t dec,
	output cu_pkg::ctrl_word_t ctrl
);
	import cu_pkg::*;

	always_comb
	begin
		ctrl.write_en = {`CU_WE_W{1'b0}};
		ctrl.bus_sel = BUS_IMEM;
		ctrl.alu_mode = ALU_PASS;
		ctrl.inc = INC_NONE;
		ctrl.clr = {`CU_CLR_W{1'b0}};
		ctrl.dm_addr = 1'b0;
		ctrl.dm_wr = 1'b0;
		ctrl.end_op = 1'b0;

		case (stage)
			// ------------------------------------------------------------------
			// fetch
			// ------------------------------------------------------------------
			FETCH1:
			begin
				ctrl.write_en.ar = 1'b1;
				ctrl.bus_sel = BUS_PC;
			end
			FETCH2:
			begin
				ctrl.write_en.dr = 1'b1; // bus stays on imem
				ctrl.inc = INC_PC;
			end
			FETCHX: ctrl.write_en.dr = 1'b1;
			FETCH3:
			begin
				ctrl.write_en.ar = 1'b1;
				ctrl.write_en.ir = 1'b1;
				ctrl.bus_sel = BUS_DR;
			end
			SKIP: ctrl.inc = INC_PC; // step over the jump target
			IDLE: ctrl.end_op = 1'b1;

			// ------------------------------------------------------------------
			// execute
			// ------------------------------------------------------------------
			EXEC1:
			begin
				case (dec.cls)
					CL_REG_LOAD, CL_ALU, CL_ALU_WB:
					begin
						ctrl.write_en.ac = 1'b1;
						ctrl.bus_sel = dec.src;
						ctrl.alu_mode = dec.alu; // pass for loads, add for wb
					end
					CL_MOVE:
					begin
						ctrl.write_en = dec.dst;
						ctrl.bus_sel = BUS_AC;
					end
					CL_CLEAR: ctrl.clr = dec.clr;
					CL_INC_AC: ctrl.inc = INC_AC;
					CL_ADDR_LOAD:
					begin
						ctrl.write_en.arb = 1'b1;
						ctrl.write_en.ar = 1'b1;
						ctrl.bus_sel = dec.src;
						ctrl.dm_addr = 1'b1;
					end
					CL_LDAC:
					begin
						ctrl.write_en.dr = 1'b1;
						ctrl.bus_sel = BUS_DMEM;
					end
					CL_LDACI, CL_STACI, CL_JPNZ, CL_JMPZ: ctrl.write_en.dr = 1'b1;
					CL_STTR:
					begin
						ctrl.bus_sel = BUS_TR;
						ctrl.dm_wr = 1'b1;
					end
					CL_END: ctrl.end_op = 1'b1;
					default: ctrl.write_en = {`CU_WE_W{1'b0}};
				endcase
			end
			EXECX:
			begin
				case (dec.cls)
					CL_STTR:
					begin
						ctrl.bus_sel = BUS_TR; // second write cycle
						ctrl.dm_wr = 1'b1;
					end
					CL_LDAC:
					begin
						ctrl.write_en.dr = 1'b1;
						ctrl.bus_sel = BUS_DMEM;
					end
					CL_LDACI:
					begin
						ctrl.write_en.arb = 1'b1;
						ctrl.write_en.ar = 1'b1;
						ctrl.bus_sel = BUS_DR;
						ctrl.dm_addr = 1'b1;
					end
					CL_STACI, CL_JPNZ, CL_JMPZ: ctrl.write_en.dr = 1'b1;
					default: ctrl.write_en = {`CU_WE_W{1'b0}};
				endcase
			end
			EXEC2:
			begin
				case (dec.cls)
					CL_ALU_WB:
					begin
						ctrl.write_en = dec.dst; // sum back to target
						ctrl.bus_sel = BUS_AC;
					end
					CL_LDAC:
					begin
						ctrl.write_en.ac = 1'b1;
						ctrl.bus_sel = BUS_DR;
					end
					CL_LDACI, CL_STACI:
					begin
						ctrl.write_en.arb = 1'b1;
						ctrl.write_en.ar = 1'b1;
						ctrl.bus_sel = BUS_DR;
						ctrl.dm_addr = 1'b1;
						ctrl.inc = INC_PC;
					end
					CL_JPNZ, CL_JMPZ:
					begin
						ctrl.write_en.pc = 1'b1;
						ctrl.bus_sel = BUS_DR;
					end
					default: ctrl.write_en = {`CU_WE_W{1'b0}};
				endcase
			end
			EXEC3, EXECY:
			begin
				if (dec.cls == CL_LDACI)
				begin
					ctrl.write_en.dr = 1'b1;
					ctrl.bus_sel = BUS_DMEM;
				end
				else if (dec.cls == CL_STACI)
				begin
					ctrl.bus_sel = BUS_AC;
					ctrl.dm_wr = (stage == EXECY); // ac settles on the bus first
				end
			end
			EXEC4:
			begin
				if (dec.cls == CL_LDACI)
				begin
					ctrl.write_en.ac = 1'b1;
					ctrl.bus_sel = BUS_DR;
				end
			end
			default: ctrl.end_op = 1'b0;
		endcase
	end

endmodule

// File: logic/cu_defs.svh
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// instruction register and opcode field
`define CU_IR_W 8
`define CU_OP_W 6

// stage register
`define CU_STAGE_W 4

// datapath control fields
`define CU_BUS_W 5
`define CU_WE_W 17
`define CU_CLR_W 5

`endif

// File: logic/cu_pkg.sv
`include "cu_defs.svh"

package cu_pkg;

	// ------------------------------------------------------------------
	// sequencer stages
	// ------------------------------------------------------------------
	typedef enum logic [`CU_STAGE_W-1:0] {
		FETCH1, FETCH2, FETCHX, FETCH3,
		EXEC1, EXECX, EXEC2, EXEC3, EXECY, EXEC4,
		SKIP, IDLE // SKIP is the not-taken jump
	} stage_e;

	// opcodes, ir[5:0]
	typedef enum logic [`CU_OP_W-1:0] {
		LDACI = 0, LDAC = 1, LDARR1 = 2, LDARR2 = 3,
		MVACR = 4, MVACRI = 5, MVACRJ = 6, MVACRK = 7,
		MVACR1 = 8, MVACR2 = 9, ADDTR = 10, ADDR1 = 11,
		ADDR2 = 12, STACI = 13, STTR = 14, MULT = 15,
		MULTRI = 16, MULTRJ = 17, MULTRK = 18, SUB = 19,
		SUBRI = 20, SUBRJ = 21, SUBRK = 22, CLRR = 23,
		CLRAC = 24, CLRTR = 25, INCAC = 26, JPNZ = 27,
		ENDOP = 28, LDACRI = 29, LDACRJ = 30, LDACRK = 31,
		LDACR3 = 32, MVACR3 = 33, LDACRA = 34, LDACRB = 35,
		MVACRA = 36, MVACRB = 37, CLRR1 = 38, CLRR2 = 39,
		LDACRC = 40, LDACRX = 41, ADDRX = 42, MVACRX = 43,
		SUBRX = 44, DIVRX = 45, MODRX = 46, JMPZ = 47
	} opcode_e;

	typedef enum logic [3:0] {
		CL_REG_LOAD, CL_MOVE, CL_ALU, CL_ALU_WB,
		CL_CLEAR, CL_INC_AC, CL_ADDR_LOAD, CL_LDAC,
		CL_LDACI, CL_STACI, CL_STTR, CL_JPNZ,
		CL_JMPZ, CL_END, CL_NOP
	} instr_class_e;

	// ------------------------------------------------------------------
	// control word fields
	// ------------------------------------------------------------------
	typedef enum logic [`CU_BUS_W-1:0] {
		BUS_IMEM, BUS_DMEM, BUS_PC, BUS_DR, BUS_R, BUS_AC, BUS_TR,
		BUS_R1, BUS_R2, BUS_RI, BUS_RJ, BUS_RK, BUS_R3,
		BUS_RA, BUS_RB, BUS_RC, BUS_RX
	} bus_src_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_MUL = 3'd2,
		ALU_DIV = 3'd3,
		ALU_PASS = 3'd4,
		ALU_MOD = 3'd5
	} alu_mode_e;

	typedef enum logic [1:0] {
		INC_NONE = 2'd0,
		INC_PC = 2'd1,
		INC_AC = 2'd2
	} inc_e;

	// register write enables, msb first
	typedef struct packed {
		logic rx, ra, rb, arb, ar;
		logic pc, dr, ir, r, tr;
		logic ac, r1, r2, ri;
		logic rj, rk, r3;
	} wr_en_t;

	typedef struct packed {
		logic r1, r2, r, ac, tr;
	} clr_t;

	typedef struct packed {
		instr_class_e cls;
		bus_src_e src; // operand register
		wr_en_t dst; // move and write-back target
		alu_mode_e alu;
		clr_t clr;
	} decoded_instr_t;

	typedef struct packed {
		wr_en_t write_en;
		bus_src_e bus_sel;
		alu_mode_e alu_mode;
		inc_e inc;
		clr_t clr;
		logic dm_addr; // data memory address from arb
		logic dm_wr;
		logic end_op;
	} ctrl_word_t;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps
`include "cu_defs.svh"

module instr_decoder (
	input logic [`CU_IR_W-1:0] ir,
	output cu_pkg::decoded_instr_t dec
);
	import cu_pkg::*;

	opcode_e op;

	assign op = opcode_e'(ir[`CU_OP_W-1:0]);

	always_comb
	begin
		dec.cls = CL_NOP; // unknown opcodes fall through as nop
		dec.src = BUS_IMEM;
		dec.dst = {`CU_WE_W{1'b0}};
		dec.alu = ALU_PASS;
		dec.clr = {`CU_CLR_W{1'b0}};

		// ------------------------------------------------------------------
		// instruction class
		// ------------------------------------------------------------------
		case (op)
			LDACRI, LDACRJ, LDACRK, LDACR3, LDACRA, LDACRB, LDACRC, LDACRX:
				dec.cls = CL_REG_LOAD;
			MVACR, MVACR1, MVACR2, MVACR3, MVACRI, MVACRJ, MVACRK, MVACRA, MVACRB, MVACRX:
				dec.cls = CL_MOVE;
			MULT, MULTRI, MULTRJ, MULTRK, SUB, SUBRI, SUBRJ, SUBRK, SUBRX, DIVRX, MODRX:
				dec.cls = CL_ALU;
			ADDTR, ADDR1, ADDR2, ADDRX: dec.cls = CL_ALU_WB;
			CLRR, CLRAC, CLRTR, CLRR1, CLRR2: dec.cls = CL_CLEAR;
			INCAC: dec.cls = CL_INC_AC;
			LDARR1, LDARR2: dec.cls = CL_ADDR_LOAD;
			LDAC: dec.cls = CL_LDAC;
			LDACI: dec.cls = CL_LDACI;
			STACI: dec.cls = CL_STACI;
			STTR: dec.cls = CL_STTR;
			JPNZ: dec.cls = CL_JPNZ;
			JMPZ: dec.cls = CL_JMPZ;
			ENDOP: dec.cls = CL_END;
			default: dec.cls = CL_NOP;
		endcase

		// operand source on the bus
		case (op)
			MULT, SUB: dec.src = BUS_R;
			LDACRI, MULTRI, SUBRI: dec.src = BUS_RI;
			LDACRJ, MULTRJ, SUBRJ: dec.src = BUS_RJ;
			LDACRK, MULTRK, SUBRK: dec.src = BUS_RK;
			LDACR3: dec.src = BUS_R3;
			LDACRA: dec.src = BUS_RA;
			LDACRB: dec.src = BUS_RB;
			LDACRC: dec.src = BUS_RC;
			LDACRX, ADDRX, SUBRX, DIVRX, MODRX: dec.src = BUS_RX;
			LDARR1, ADDR1: dec.src = BUS_R1;
			LDARR2, ADDR2: dec.src = BUS_R2;
			ADDTR: dec.src = BUS_TR;
			default: dec.src = BUS_IMEM;
		endcase

		// destination for moves and write-backs
		case (op)
			MVACR: dec.dst.r = 1'b1;
			MVACR1, ADDR1: dec.dst.r1 = 1'b1;
			MVACR2, ADDR2: dec.dst.r2 = 1'b1;
			MVACR3: dec.dst.r3 = 1'b1;
			MVACRI: dec.dst.ri = 1'b1;
			MVACRJ: dec.dst.rj = 1'b1;
			MVACRK: dec.dst.rk = 1'b1;
			MVACRA: dec.dst.ra = 1'b1; // ra only, no rk
			MVACRB: dec.dst.rb = 1'b1;
			MVACRX, ADDRX: dec.dst.rx = 1'b1;
			ADDTR: dec.dst.tr = 1'b1;
			default: dec.dst = {`CU_WE_W{1'b0}};
		endcase

		case (op)
			MULT, MULTRI, MULTRJ, MULTRK: dec.alu = ALU_MUL;
			SUB, SUBRI, SUBRJ, SUBRK, SUBRX: dec.alu = ALU_SUB;
			DIVRX: dec.alu = ALU_DIV;
			MODRX: dec.alu = ALU_MOD;
			ADDTR, ADDR1, ADDR2, ADDRX: dec.alu = ALU_ADD;
			default: dec.alu = ALU_PASS;
		endcase

		case (op)
			CLRR: dec.clr.r = 1'b1;
			CLRAC: dec.clr.ac = 1'b1;
			CLRTR: dec.clr.tr = 1'b1;
			CLRR1: dec.clr.r1 = 1'b1;
			CLRR2: dec.clr.r2 = 1'b1;
			default: dec.clr = {`CU_CLR_W{1'b0}};
		endcase
	end

endmodule

// File: logic/stage_sequencer.sv
`timescale 1ns/1ps

module stage_sequencer (
	input logic clk,
	input logic arst_n,
	input cu_pkg::instr_class_e cls,
	input logic z,
	input logic en,
	output cu_pkg::stage_e stage
);
	import cu_pkg::*;

	stage_e next_stage;
	logic jump_taken;

	// z is only looked at while in FETCH3
	assign jump_taken = (cls == CL_JPNZ && !z) || (cls == CL_JMPZ && z);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			stage <= FETCH1;
		else
			stage <= next_stage;
	end

	// ------------------------------------------------------------------
	// next stage
	// ------------------------------------------------------------------
	always_comb
	begin
		next_stage = FETCH1;
		case (stage)
			FETCH1: next_stage = en ? FETCH2 : IDLE; // stop when disabled
			FETCH2: next_stage = FETCHX;
			FETCHX: next_stage = FETCH3;
			FETCH3:
			begin
				if ((cls == CL_JPNZ || cls == CL_JMPZ) && !jump_taken)
					next_stage = SKIP;
				else
					next_stage = EXEC1;
			end
			EXEC1:
			begin
				case (cls)
					CL_ALU_WB: next_stage = EXEC2;
					CL_STTR, CL_LDAC, CL_LDACI, CL_STACI, CL_JPNZ, CL_JMPZ:
						next_stage = EXECX;
					CL_END: next_stage = IDLE;
					default: next_stage = FETCH1; // single-cycle classes
				endcase
			end
			EXECX:
			begin
				case (cls)
					CL_LDAC, CL_LDACI, CL_STACI, CL_JPNZ, CL_JMPZ: next_stage = EXEC2;
					default: next_stage = FETCH1; // sttr done
				endcase
			end
			EXEC2: next_stage = (cls == CL_LDACI || cls == CL_STACI) ? EXEC3 : FETCH1;
			EXEC3: next_stage = EXECY;
			EXECY: next_stage = (cls == CL_LDACI) ? EXEC4 : FETCH1;
			EXEC4: next_stage = FETCH1;
			SKIP: next_stage = FETCH1;
			IDLE: next_stage = IDLE; // held until reset
			default: next_stage = FETCH1;
		endcase
	end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module control_unit_tb -o control_unit_tb
./obj_dir/control_unit_tb > sim.log
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
else
	exit 1
fi

// File: sim.f
+incdir+logic
+incdir+tb
logic/cu_pkg.sv
logic/instr_decoder.sv
logic/stage_sequencer.sv
logic/control_word_gen.sv
logic/control_unit.sv
tb/control_unit_tb.sv

// File: tb/cu_vectors.svh
`ifndef CU_VECTORS_SVH
`define CU_VECTORS_SVH

// one row per instruction: opcode, z select, en, execute cycles,
// then the expected control word of each execute cycle in order
task automatic build_table();
	n_rows = 0;

	// ------------------------------------------------------------------
	// single-cycle classes
	// ------------------------------------------------------------------
	add_single(LDACRI, Z_ANY, load_word(BUS_AC, BUS_RI, ALU_PASS));
	add_single(LDACRB, Z_ANY, load_word(BUS_AC, BUS_RB, ALU_PASS));
	add_single(LDACRX, Z_ANY, load_word(BUS_AC, BUS_RX, ALU_PASS));
	add_single(MVACR, Z_ANY, load_word(BUS_R, BUS_AC, ALU_PASS));
	add_single(MVACR1, Z_ANY, load_word(BUS_R1, BUS_AC, ALU_PASS));
	add_single(MVACRA, Z_ANY, load_word(BUS_RA, BUS_AC, ALU_PASS)); // ra alone
	add_single(MVACRX, Z_ANY, load_word(BUS_RX, BUS_AC, ALU_PASS));
	add_single(MULT, Z_ANY, load_word(BUS_AC, BUS_R, ALU_MUL));
	add_single(SUBRJ, Z_ANY, load_word(BUS_AC, BUS_RJ, ALU_SUB));
	add_single(DIVRX, Z_ANY, load_word(BUS_AC, BUS_RX, ALU_DIV));
	add_single(MODRX, Z_ANY, load_word(BUS_AC, BUS_RX, ALU_MOD));
	add_single(CLRR, Z_ANY, clear_word(BUS_R));
	add_single(CLRAC, Z_ANY, clear_word(BUS_AC));
	add_single(CLRTR, Z_ANY, clear_word(BUS_TR));
	add_single(CLRR1, Z_ANY, clear_word(BUS_R1));
	add_single(CLRR2, Z_ANY, clear_word(BUS_R2));
	add_single(INCAC, Z_ANY, inc_word(INC_AC));
	add_single(LDARR1, Z_ANY, addr_word(BUS_R1));
	add_single(LDARR2, Z_ANY, addr_word(BUS_R2));
	add_single(6'd50, Z_ANY, blank_word()); // unknown opcode, plain nop
	add_single(ENDOP, Z_ANY, end_word());

	// ------------------------------------------------------------------
	// multi-cycle classes
	// ------------------------------------------------------------------
	start_row(ADDTR, Z_ANY, 1'b1, 2);
	add_word(load_word(BUS_AC, BUS_TR, ALU_ADD));
	add_word(load_word(BUS_TR, BUS_AC, ALU_PASS));
	start_row(ADDRX, Z_ANY, 1'b1, 2);
	add_word(load_word(BUS_AC, BUS_RX, ALU_ADD));
	add_word(load_word(BUS_RX, BUS_AC, ALU_PASS));

	start_row(LDAC, Z_ANY, 1'b1, 3);
	add_word(load_word(BUS_DR, BUS_DMEM, ALU_PASS));
	add_word(load_word(BUS_DR, BUS_DMEM, ALU_PASS));
	add_word(load_word(BUS_AC, BUS_DR, ALU_PASS));

	start_row(LDACI, Z_ANY, 1'b1, 6);
	add_word(load_word(BUS_DR, BUS_IMEM, ALU_PASS));
	add_word(addr_word(BUS_DR));
	add_word(plus_inc_pc(addr_word(BUS_DR)));
	add_word(load_word(BUS_DR, BUS_DMEM, ALU_PASS));
	add_word(load_word(BUS_DR, BUS_DMEM, ALU_PASS));
	add_word(load_word(BUS_AC, BUS_DR, ALU_PASS));

	start_row(STACI, Z_ANY, 1'b1, 5);
	add_word(load_word(BUS_DR, BUS_IMEM, ALU_PASS));
	add_word(load_word(BUS_DR, BUS_IMEM, ALU_PASS));
	add_word(plus_inc_pc(addr_word(BUS_DR)));
	add_word(bus_word(BUS_AC, 1'b0));
	add_word(bus_word(BUS_AC, 1'b1)); // write lands on the last cycle

	start_row(STTR, Z_ANY, 1'b1, 2);
	add_word(bus_word(BUS_TR, 1'b1));
	add_word(bus_word(BUS_TR, 1'b1));

	// ------------------------------------------------------------------
	// jumps, both polarities of z
	// ------------------------------------------------------------------
	start_row(JPNZ, Z_LO, 1'b1, 3);
	add_word(load_word(BUS_DR, BUS_IMEM, ALU_PASS));
	add_word(load_word(BUS_DR, BUS_IMEM, ALU_PASS));
	add_word(load_word(BUS_PC, BUS_DR, ALU_PASS));
	add_single(JPNZ, Z_HI, inc_word(INC_PC));
	start_row(JMPZ, Z_HI, 1'b1, 3);
	add_word(load_word(BUS_DR, BUS_IMEM, ALU_PASS));
	add_word(load_word(BUS_DR, BUS_IMEM, ALU_PASS));
	add_word(load_word(BUS_PC, BUS_DR, ALU_PASS));
	add_single(JMPZ, Z_LO, inc_word(INC_PC));

	start_row(INCAC, Z_ANY, 1'b0, 0); // en low, fetch1 goes to idle
endtask

`endif

// File: tb/control_unit_tb.sv
`timescale 1ns/1ps
`include "cu_defs.svh"

module control_unit_tb;
	import cu_pkg::*;

	localparam int MAX_ROWS = 40;
	localparam int FETCH_TIMEOUT = 12; // cycles to reach fetch3
	localparam logic [1:0] Z_LO = 2'd0;
	localparam logic [1:0] Z_HI = 2'd1;
	localparam logic [1:0] Z_ANY = 2'd2;

	typedef struct packed {
		logic [`CU_OP_W-1:0] op;
		logic [1:0] z_sel;
		logic en;
		logic [2:0] n_exec;
		ctrl_word_t [5:0] words; // one per execute cycle
	} vec_t;

	logic clk;
	logic arst_n;
	logic [`CU_IR_W-1:0] ir;
	logic z;
	logic en;
	ctrl_word_t ctrl;

	vec_t vecs [MAX_ROWS];
	int n_rows;
	int fill_idx;
	int errors;
	int row_errors;
	int rows_failed;
	int checks;
	logic timed_out;

	control_unit dut_i (
		.clk (clk),
		.arst_n (arst_n),
		.ir (ir),
		.z (z),
		.en (en),
		.ctrl (ctrl)
	);

	always #2 clk = ~clk;

	// ------------------------------------------------------------------
	// expected control words
	// ------------------------------------------------------------------
	function automatic ctrl_word_t blank_word();
		ctrl_word_t w;
		w = '0;
		w.bus_sel = BUS_IMEM;
		w.alu_mode = ALU_PASS;
		w.inc = INC_NONE;
		return w;
	endfunction

	function automatic wr_en_t we_of(input bus_src_e dst);
		wr_en_t we;
		we = '0;
		case (dst)
			BUS_PC: we.pc = 1'b1;
			BUS_DR: we.dr = 1'b1;
			BUS_R: we.r = 1'b1;
			BUS_AC: we.ac = 1'b1;
			BUS_TR: we.tr = 1'b1;
			BUS_R1: we.r1 = 1'b1;
			BUS_RA: we.ra = 1'b1;
			BUS_RX: we.rx = 1'b1;
			default: we = '0;
		endcase
		return we;
	endfunction

	// dst written from the bus source through the given alu mode
	function automatic ctrl_word_t load_word(input bus_src_e dst, input bus_src_e src,
		input alu_mode_e alu);
		ctrl_word_t w;
		w = blank_word();
		w.write_en = we_of(dst);
		w.bus_sel = src;
		w.alu_mode = alu;
		return w;
	endfunction

	function automatic ctrl_word_t fetch_word(input int step);
		ctrl_word_t w;
		w = blank_word();
		case (step)
			0:
			begin
				w.write_en.ar = 1'b1;
				w.bus_sel = BUS_PC;
			end
			1:
			begin
				w.write_en.dr = 1'b1;
				w.inc = INC_PC;
			end
			2: w.write_en.dr = 1'b1;
			default:
			begin
				w.write_en.ar = 1'b1; // ar and ir together mark fetch3
				w.write_en.ir = 1'b1;
				w.bus_sel = BUS_DR;
			end
		endcase
		return w;
	endfunction

	function automatic ctrl_word_t addr_word(input bus_src_e src);
		ctrl_word_t w;
		w = blank_word();
		w.write_en.arb = 1'b1;
		w.write_en.ar = 1'b1;
		w.bus_sel = src;
		w.dm_addr = 1'b1;
		return w;
	endfunction

	function automatic ctrl_word_t bus_word(input bus_src_e src, input logic wr);
		ctrl_word_t w;
		w = blank_word();
		w.bus_sel = src;
		w.dm_wr = wr;
		return w;
	endfunction

	function automatic ctrl_word_t inc_word(input inc_e inc);
		ctrl_word_t w;
		w = blank_word();
		w.inc = inc;
		return w;
	endfunction

	function automatic ctrl_word_t clear_word(input bus_src_e reg_id);
		ctrl_word_t w;
		w = blank_word();
		case (reg_id)
			BUS_R1: w.clr.r1 = 1'b1;
			BUS_R2: w.clr.r2 = 1'b1;
			BUS_R: w.clr.r = 1'b1;
			BUS_AC: w.clr.ac = 1'b1;
			default: w.clr.tr = 1'b1;
		endcase
		return w;
	endfunction

	function automatic ctrl_word_t end_word();
		ctrl_word_t w;
		w = blank_word();
		w.end_op = 1'b1;
		return w;
	endfunction

	function automatic ctrl_word_t plus_inc_pc(input ctrl_word_t w_in);
		ctrl_word_t w;
		w = w_in;
		w.inc = INC_PC;
		return w;
	endfunction

	// ------------------------------------------------------------------
	// table building
	// ------------------------------------------------------------------
	task automatic start_row(input logic [`CU_OP_W-1:0] op, input logic [1:0] z_sel,
		input logic en_val, input int n_exec);
		if (n_rows < MAX_ROWS)
		begin
			vecs[n_rows].op = op;
			vecs[n_rows].z_sel = z_sel;
			vecs[n_rows].en = en_val;
			vecs[n_rows].n_exec = 3'(n_exec);
			vecs[n_rows].words = '0;
			n_rows++;
		end
		fill_idx = 0;
	endtask

	task automatic add_word(input ctrl_word_t w);
		if (n_rows > 0 && fill_idx < 6)
			vecs[n_rows - 1].words[fill_idx] = w;
		fill_idx++;
	endtask

	task automatic add_single(input logic [`CU_OP_W-1:0] op, input logic [1:0] z_sel,
		input ctrl_word_t w);
		start_row(op, z_sel, 1'b1, 1);
		add_word(w);
	endtask

	`include "cu_vectors.svh"

	// ------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------
	task automatic check_word(input string name, input ctrl_word_t got, input ctrl_word_t want);
		checks++;
		if (got !== want)
		begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, want);
			errors++;
			row_errors++;
		end
	endtask

	task automatic check_we(input string name, input wr_en_t got, input wr_en_t want);
		checks++;
		if (got !== want)
		begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, want);
			errors++;
			row_errors++;
		end
	endtask

	task automatic check_bus(input string name, input bus_src_e got, input bus_src_e want);
		checks++;
		if (got !== want)
		begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, want);
			errors++;
			row_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		checks++;
		if (got !== want)
		begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, want);
			errors++;
			row_errors++;
		end
	endtask

	// ------------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------------
	// ends at the falling edge of the first cycle in fetch1
	task automatic apply_reset(input logic [`CU_IR_W-1:0] ir_val, input logic z_val,
		input logic en_val);
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		ir = ir_val;
		z = z_val;
		en = en_val;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
	endtask

	task automatic wait_fetch3(output logic found);
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < FETCH_TIMEOUT)
		begin
			if (ctrl.write_en.ar && ctrl.write_en.ir)
				found = 1'b1;
			else
			begin
				check_bit("ctrl.dm_wr", ctrl.dm_wr, 1'b0);
				check_bit("ctrl.end_op", ctrl.end_op, 1'b0);
				@(negedge clk);
				n++;
			end
		end
	endtask

	task automatic fetch_test();
		ctrl_word_t want;
		int k;
		row_errors = 0;
		apply_reset({{(`CU_IR_W - `CU_OP_W){1'b0}}, INCAC}, 1'b0, 1'b1);
		for (k = 0; k < 4; k++)
		begin
			want = fetch_word(k);
			check_we("ctrl.write_en", ctrl.write_en, want.write_en);
			check_bus("ctrl.bus_sel", ctrl.bus_sel, want.bus_sel);
			check_word("ctrl", ctrl, want);
			check_bit("ctrl.dm_wr", ctrl.dm_wr, 1'b0);
			check_bit("ctrl.end_op", ctrl.end_op, 1'b0);
			@(negedge clk);
		end
		if (row_errors != 0)
			rows_failed++;
		$display("fetch after reset: %0d mismatches", row_errors);
	endtask

	task automatic run_row(input int idx);
		vec_t v;
		logic z_val;
		logic found;
		logic [31:0] rnd;
		int n_exec;
		int k;
		v = vecs[idx];
		n_exec = int'(v.n_exec);
		row_errors = 0;
		rnd = $urandom;
		case (v.z_sel)
			Z_LO: z_val = 1'b0;
			Z_HI: z_val = 1'b1;
			default: z_val = rnd[0]; // z has no effect on this class
		endcase
		apply_reset({{(`CU_IR_W - `CU_OP_W){1'b0}}, v.op}, z_val, v.en);
		if (!v.en)
		begin
			check_word("ctrl in fetch1", ctrl, fetch_word(0));
			@(negedge clk);
			check_word("ctrl after fetch1", ctrl, end_word());
			@(negedge clk);
			check_word("ctrl in idle", ctrl, end_word());
		end
		else
		begin
			wait_fetch3(found);
			if (!found)
			begin
				$display("row %0d never reached the fetch3 word", idx);
				timed_out = 1'b1;
				row_errors++;
			end
			else
			begin
				for (k = 0; k < n_exec; k++)
				begin
					@(negedge clk);
					check_word($sformatf("ctrl exec %0d", k + 1), ctrl, v.words[k]);
				end
				@(negedge clk);
				if (v.op == ENDOP)
				begin
					check_word("ctrl in idle", ctrl, end_word());
					@(negedge clk);
					check_word("ctrl in idle", ctrl, end_word());
				end
				else
					check_word("ctrl after exec", ctrl, fetch_word(0));
			end
		end
		if (row_errors != 0)
			rows_failed++;
		$display("row %0d op %0d z %0b en %0b: %0d mismatches", idx, v.op, z_val, v.en,
			row_errors);
	endtask

	initial
	begin
		int r;
		clk = 1'b0;
		arst_n = 1'b0;
		ir = '0;
		z = 1'b0;
		en = 1'b0;
		errors = 0;
		rows_failed = 0;
		checks = 0;
		timed_out = 1'b0;
		void'($urandom(32'hdfe6797b));
		build_table();
		fetch_test();
		for (r = 0; r < n_rows && !timed_out; r++)
			run_row(r);
		$display("tests %0d, failed %0d, checks %0d, errors %0d", n_rows + 1, rows_failed,
			checks, errors);
		if (errors == 0 && rows_failed == 0 && !timed_out)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
